// File: verilog.f
+incdir+hw
hw/cvt_types_pkg.sv
hw/cvt_cfg_pkg.sv
hw/cvt_ctrl_if.sv
hw/cvt_sort_if.sv
hw/cvt_fsm.sv
hw/cvt_sort_counter.sv
hw/cvt_store.sv
hw/cvt_sort_mem.sv
hw/cvt_top.sv
test/cvt_checker.sv
test/cvt_tb.sv

// File: test/cvt_tb.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

module cvt_tb;

	localparam int  NUM_FRAMES   = 6;
	localparam int  FRAME_WORDS  = `CVT_CFG_WORDS + 2 * `CVT_BANK_DEPTH;   // config + payload
	localparam int  FRAME_CYCLES = 800;   // upper bound for one frame
	localparam int  RESET_CYCLES = 10;
	localparam real CLK_NS       = 8.0;

	logic                      clk;
	logic                      reset;
	logic [`CVT_WORD_BITS-1:0] din_data;
	logic                      din_empty_n;
	logic                      din_read;
	logic                      dout_full_n;
	logic [`CVT_WORD_BITS-1:0] dout_data;
	logic                      dout_last;
	logic                      dout_write;
	cvt_types_pkg::cvt_state_e state;
	int                        data_errors;
	int                        proto_errors;
	int                        frames_done;
	logic [15:0]               lfsr;
	logic [`CVT_WORD_BITS-1:0] frame_words [FRAME_WORDS];

	cvt_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.din_data    (din_data),
		.din_empty_n (din_empty_n),
		.din_read    (din_read),
		.dout_full_n (dout_full_n),
		.dout_data   (dout_data),
		.dout_last   (dout_last),
		.dout_write  (dout_write),
		.state       (state)
	);

	cvt_checker i_checker (
		.clk          (clk),
		.reset        (reset),
		.din_read     (din_read),
		.dout_data    (dout_data),
		.dout_last    (dout_last),
		.dout_write   (dout_write),
		.dout_full_n  (dout_full_n),
		.state        (state),
		.data_errors  (data_errors),
		.proto_errors (proto_errors),
		.frames_done  (frames_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// =========================================================================
	// random source and frame setup
	// =========================================================================
	// x^16 + x^14 + x^13 + x^11 + 1, right shifting
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// {mode, ch_step, chpart_step, ch_part_num} per frame
	function automatic logic [127:0] frame_config(input int f);
		case (f)
			0:       return {32'd1, 32'd2, 32'd0, 32'd1};   // transpose, one part
			1:       return {32'd1, 32'd1, 32'd8, 32'd2};   // transpose, two parts
			2:       return {32'd2, 32'd7, 32'd3, 32'd2};   // copy, other fields unused
			3:       return {32'd5, 32'd2, 32'd0, 32'd1};   // unknown code, copy
			4:       return {32'd1, 32'd1, 32'd8, 32'd2};
			default: return {32'd1, 32'd2, 32'd0, 32'd1};
		endcase
	endfunction

	task automatic build_frame(input int f);
		logic [127:0] c;
		logic [63:0]  r;
		c              = frame_config(f);
		frame_words[0] = c[127:64];
		frame_words[1] = c[63:0];
		for (int i = `CVT_CFG_WORDS; i < FRAME_WORDS; i++) begin
			take_bits(64, r);
			frame_words[i] = r;
		end
		for (int i = 0; i < FRAME_WORDS; i++) begin
			i_checker.load_word(frame_words[i]);   // expected data goes to the checker
		end
	endtask

	task automatic print_counts();
		$display("errors: data %0d, protocol %0d, frames checked %0d of %0d",
			data_errors, proto_errors, frames_done, NUM_FRAMES);
	endtask

	// =========================================================================
	// stimulus, one pass per clock
	// =========================================================================
	initial begin : stimulus
		int          frame;
		int          idx;
		int          gap;
		logic [63:0] r;
		reset       = 1'b1;
		din_data    = '0;
		din_empty_n = 1'b0;
		dout_full_n = 1'b0;
		lfsr        = 16'd55031;
		frame       = 0;
		idx         = 0;
		gap         = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		build_frame(0);
		while (frames_done < NUM_FRAMES) begin
			@(posedge clk);
			if (din_read && din_empty_n) begin   // beat taken at this edge
				idx++;
			end
			if (idx == FRAME_WORDS) begin
				frame++;
				idx = 0;
				take_bits(3, r);
				gap = int'(r);   // 0 to 7 idle cycles
				if (frame < NUM_FRAMES) begin
					build_frame(frame);
				end
			end
			if (frame < NUM_FRAMES && gap == 0) begin
				take_bits(2, r);
				din_data    <= frame_words[idx];
				din_empty_n <= (r[1:0] != 2'b00);   // about one cycle in four empty
			end else begin
				din_empty_n <= 1'b0;
				if (gap > 0) begin
					gap--;
				end
			end
			take_bits(2, r);
			dout_full_n <= (r[1:0] != 2'b00);   // random back-pressure
		end
		repeat (4) @(posedge clk);
		print_counts();
		if (data_errors == 0 && proto_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin : watchdog
		#((RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES) * CLK_NS);
		$display("timeout: only %0d of %0d frames came out in time", frames_done, NUM_FRAMES);
		print_counts();
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: test/cvt_checker.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

module cvt_checker (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      din_read,
	input  logic [`CVT_WORD_BITS-1:0] dout_data,
	input  logic                      dout_last,
	input  logic                      dout_write,
	input  logic                      dout_full_n,
	input  cvt_types_pkg::cvt_state_e state,
	output int                        data_errors,
	output int                        proto_errors,
	output int                        frames_done
);
	localparam int W      = `CVT_WORD_BITS;
	localparam int LANES  = `CVT_LANES;
	localparam int DEPTH  = `CVT_BANK_DEPTH;
	localparam int NWORDS = `CVT_SORT_DEPTH;
	localparam int CFG_N  = `CVT_CFG_WORDS;

	logic [W-1:0] word_q [$];        // input frames, config beats first
	logic [W-1:0] cfg_w [CFG_N];
	logic [W-1:0] payload [NWORDS];
	int           out_idx;           // beat index inside the output frame
	int           n_data;
	int           n_proto;
	int           n_frames;
	logic         seen_idle;         // IDLE seen since the last frame ended
	logic         held;              // beat stalled at the previous edge
	logic [W-1:0] held_data;
	logic         held_last;

	task automatic load_word(input logic [W-1:0] w);
		word_q.push_back(w);
	endtask

	// =========================================================================
	// reference model
	// =========================================================================
	function automatic logic [W-1:0] expected_word(input int e);
		logic [31:0]  mode;
		int           ch_step;
		int           chpart_step;
		int           parts;
		int           part;
		int           bank;
		int           byte_i;
		int           col;
		int           addr;
		logic [W-1:0] src;
		logic [W-1:0] res;
		mode        = cfg_w[0][W-1 -: 32];
		ch_step     = int'(cfg_w[0][31:0]);
		chpart_step = int'(cfg_w[1][W-1 -: 32]);
		parts       = int'(cfg_w[1][31:0]);
		if (mode != 32'd1) begin
			return payload[e];   // row-major copy, unknown codes too
		end
		// entry order col_part, byte, bank, ch_part with ch_part fastest
		part   = e % parts;
		bank   = (e / parts) % 2;
		byte_i = (e / parts / 2) % LANES;
		col    = e / parts / (2 * LANES);
		res    = '0;
		for (int k = 0; k < LANES; k++) begin
			addr = (k * ch_step + part * chpart_step + col) % DEPTH;   // wraps inside the bank
			src  = payload[bank * DEPTH + addr];
			res[W-1 - 8*k -: 8] = src[W-1 - 8*byte_i -: 8];   // byte 0 / lane 0 on top
		end
		return res;
	endfunction

	// =========================================================================
	// output checks
	// =========================================================================
	task automatic check_hold();
		if (!dout_write) begin
			$display("error: dout_write dropped while dout_full_n was low");
			n_proto++;
		end
		if (dout_data !== held_data) begin
			$display("mismatch dout_data during stall expected %h actual %h",
				held_data, dout_data);
			n_data++;
		end
		if (dout_last !== held_last) begin
			$display("mismatch dout_last during stall expected %h actual %h",
				held_last, dout_last);
			n_data++;
		end
	endtask

	task automatic check_output_word();
		logic [W-1:0] exp;
		logic         exp_last;
		if (out_idx == 0) begin   // first beat, fetch the matching input frame
			if (n_frames > 0 && !seen_idle) begin
				$display("error: state did not return to IDLE before frame %0d", n_frames);
				n_proto++;
			end
			if (word_q.size() < CFG_N + NWORDS) begin
				$display("error: output frame %0d has no matching input frame", n_frames);
				n_proto++;
			end else begin
				for (int i = 0; i < CFG_N; i++) begin
					cfg_w[i] = word_q.pop_front();
				end
				for (int i = 0; i < NWORDS; i++) begin
					payload[i] = word_q.pop_front();
				end
			end
		end
		exp      = expected_word(out_idx);
		exp_last = (out_idx == NWORDS - 1);
		if (dout_data !== exp) begin
			$display("mismatch frame %0d word %0d dout_data expected %h actual %h",
				n_frames, out_idx, exp, dout_data);
			n_data++;
		end
		if (dout_last !== exp_last) begin
			$display("mismatch frame %0d word %0d dout_last expected %h actual %h",
				n_frames, out_idx, exp_last, dout_last);
			n_data++;
		end
		if (exp_last) begin
			out_idx   = 0;
			n_frames++;
			seen_idle = 1'b0;
		end else begin
			out_idx++;
		end
	endtask

	initial begin
		out_idx   = 0;
		n_data    = 0;
		n_proto   = 0;
		n_frames  = 0;
		seen_idle = 1'b1;
		held      = 1'b0;
		held_data = '0;
		held_last = 1'b0;
	end

	always @(posedge clk) begin
		if (reset) begin
			if (din_read || dout_write || dout_last || state != cvt_types_pkg::IDLE) begin
				$display("error: strobes not low or state not IDLE during reset");
				n_proto++;
			end
		end else begin
			if (state == cvt_types_pkg::IDLE) begin
				seen_idle = 1'b1;
			end
			if (held) begin
				check_hold();
			end
			if (dout_write && dout_full_n) begin   // beat moves
				check_output_word();
			end
			held      = dout_write & ~dout_full_n;
			held_data = dout_data;
			held_last = dout_last;
		end
		data_errors  <= n_data;
		proto_errors <= n_proto;
		frames_done  <= n_frames;
	end

endmodule

// File: hw/cvt_top.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

module cvt_top (
	input  logic                      clk,
	input  logic                      reset,
	// input stream
	input  logic [`CVT_WORD_BITS-1:0] din_data,
	input  logic                      din_empty_n,
	output logic                      din_read,
	// output stream
	input  logic                      dout_full_n,
	output logic [`CVT_WORD_BITS-1:0] dout_data,
	output logic                      dout_last,
	output logic                      dout_write,
	output cvt_types_pkg::cvt_state_e state   // observation
);
	cvt_cfg_pkg::cvt_cfg_t     cfg;
	logic [`CVT_WORD_BITS-1:0] bank_data;

	cvt_ctrl_if ctrl_bus ();
	cvt_sort_if sort_bus ();

	cvt_fsm i_fsm (
		.clk         (clk),
		.reset       (reset),
		.din_empty_n (din_empty_n),
		.ctrl        (ctrl_bus.fsm),
		.state       (state)
	);

	cvt_store i_store (
		.clk         (clk),
		.reset       (reset),
		.din_data    (din_data),
		.din_empty_n (din_empty_n),
		.din_read    (din_read),
		.cfg         (cfg),
		.bank_data   (bank_data),
		.ctrl        (ctrl_bus.unit),
		.sort        (sort_bus.sink)
	);

	cvt_sort_counter i_sort_counter (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg),
		.ctrl  (ctrl_bus.unit),
		.sort  (sort_bus.source)
	);

	cvt_sort_mem i_sort_mem (
		.clk         (clk),
		.reset       (reset),
		.bank_data   (bank_data),
		.dout_full_n (dout_full_n),
		.dout_data   (dout_data),
		.dout_last   (dout_last),
		.dout_write  (dout_write),
		.ctrl        (ctrl_bus.unit),
		.sort        (sort_bus.sink)
	);

endmodule

// File: hw/cvt_sort_mem.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

module cvt_sort_mem (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`CVT_WORD_BITS-1:0] bank_data,
	input  logic                      dout_full_n,
	output logic [`CVT_WORD_BITS-1:0] dout_data,
	output logic                      dout_last,
	output logic                      dout_write,
	cvt_ctrl_if.unit                  ctrl,
	cvt_sort_if.sink                  sort
);
	localparam int W       = `CVT_WORD_BITS;
	localparam int LANES   = `CVT_LANES;
	localparam int LANE_W  = $clog2(LANES);
	localparam int SORT_AW = $clog2(`CVT_SORT_DEPTH);

	// stage 1, lines up with bank_data
	logic              s1_step;
	logic [LANE_W:0]   s1_lane;
	logic [LANE_W-1:0] s1_byte;
	logic [SORT_AW-1:0] s1_addr;
	logic [7:0]        pick;
	logic [W-1:0]      wr_data;
	logic [LANES-1:0]  wr_be;
	// stage 2, memory write
	logic              s2_we;
	logic [SORT_AW-1:0] s2_addr;
	logic [W-1:0]      s2_data;
	logic [LANES-1:0]  s2_be;
	logic [W-1:0]      sort_mem [`CVT_SORT_DEPTH];
	// output side
	logic              adv;        // pipeline moves
	logic              rd_issue;
	logic [SORT_AW:0]  rd_cnt;     // counts to DEPTH, then idles
	logic              a_vld;
	logic              a_last;
	logic [W-1:0]      rd_data;

	// =========================================================================
	// byte gather, byte 0 and lane 0 are the most significant
	// =========================================================================
	assign pick = bank_data[W-1 - 8*s1_byte -: 8];

	always_comb begin
		if (s1_lane == (LANE_W+1)'(LANES)) begin
			wr_data = bank_data;   // row-major copy
			wr_be   = '1;
		end else begin
			wr_data = {LANES{pick}};
			wr_be   = {1'b1, {(LANES-1){1'b0}}} >> s1_lane[LANE_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1_step <= 1'b0;
			s2_we   <= 1'b0;
		end else begin
			s1_step <= sort.step;
			s2_we   <= s1_step;
		end
	end

	always_ff @(posedge clk) begin
		s1_lane <= sort.lane;
		s1_byte <= sort.byte_sel;
		s1_addr <= sort.sort_addr;
		s2_addr <= s1_addr;
		s2_data <= wr_data;
		s2_be   <= wr_be;
		for (int i = 0; i < LANES; i++) begin
			if (s2_we & s2_be[i]) begin
				sort_mem[s2_addr][8*i +: 8] <= s2_data[8*i +: 8];
			end
		end
		if (rd_issue & adv) begin
			rd_data <= sort_mem[rd_cnt[SORT_AW-1:0]];
		end
		if (a_vld & adv) begin
			dout_data <= rd_data;
		end
	end

	// =========================================================================
	// output pipeline, everything holds while full_n is low
	// =========================================================================
	assign adv      = dout_full_n;
	assign rd_issue = (ctrl.state == cvt_types_pkg::OUTPUT)
		& (rd_cnt < (SORT_AW+1)'(`CVT_SORT_DEPTH));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_cnt     <= '0;
			a_vld      <= 1'b0;
			a_last     <= 1'b0;
			dout_write <= 1'b0;
			dout_last  <= 1'b0;
		end else if (ctrl.clear) begin
			rd_cnt <= '0;   // pipeline already empty here
		end else if (adv) begin
			if (rd_issue) begin
				rd_cnt <= rd_cnt + 1'b1;
			end
			a_vld      <= rd_issue;
			a_last     <= rd_issue & (rd_cnt == (SORT_AW+1)'(`CVT_SORT_DEPTH - 1));
			dout_write <= a_vld;
			dout_last  <= a_last;
		end
	end

	assign ctrl.out_done = dout_write & dout_last & dout_full_n;   // entry 31 taken

endmodule

// File: hw/cvt_store.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

module cvt_store (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`CVT_WORD_BITS-1:0]  din_data,
	input  logic                       din_empty_n,
	output logic                       din_read,
	output cvt_cfg_pkg::cvt_cfg_t      cfg,
	output logic [`CVT_WORD_BITS-1:0]  bank_data,   // one cycle after the sort address
	cvt_ctrl_if.unit                   ctrl,
	cvt_sort_if.sink                   sort
);
	localparam int HALF    = `CVT_WORD_BITS / 2;
	localparam int BANK_AW = $clog2(`CVT_BANK_DEPTH);
	localparam int ST_W    = BANK_AW + 1;              // top bit picks the bank
	localparam int CFG_W   = $clog2(`CVT_CFG_WORDS);

	logic in_cfg;
	logic in_store;
	logic take;                 // beat accepted this cycle
	logic [CFG_W-1:0] cfg_cnt;
	logic [ST_W-1:0]  st_cnt;   // payload beat index
	logic [`CVT_WORD_BITS-1:0] bank_mem [2][`CVT_BANK_DEPTH];

	assign in_cfg   = (ctrl.state == cvt_types_pkg::CFG_READ);
	assign in_store = (ctrl.state == cvt_types_pkg::STORE);
	assign take     = din_read & din_empty_n;

	assign ctrl.cfg_done   = take & in_cfg & (cfg_cnt == CFG_W'(`CVT_CFG_WORDS - 1));
	assign ctrl.store_done = take & in_store & (st_cnt == '1);

	// =========================================================================
	// read level and beat counters
	// =========================================================================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			din_read <= 1'b0;
			cfg_cnt  <= '0;
			st_cnt   <= '0;
		end else begin
			// drops on the last payload beat so the next frame stays queued
			din_read <= din_empty_n & (in_cfg | (in_store & ~ctrl.store_done));
			if (ctrl.clear) begin
				cfg_cnt <= '0;
				st_cnt  <= '0;
			end else begin
				if (take & in_cfg) begin
					cfg_cnt <= cfg_cnt + 1'b1;
				end
				if (take & in_store) begin
					st_cnt <= st_cnt + 1'b1;
				end
			end
		end
	end

	// config capture
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cfg.mode        <= cvt_types_pkg::MODE_ROW_MAJOR;
			cfg.ch_step     <= '0;
			cfg.chpart_step <= '0;
			cfg.ch_part_num <= 32'd1;
		end else if (take & in_cfg) begin
			if (cfg_cnt == '0) begin
				cfg.mode    <= cvt_types_pkg::cvt_mode_e'(din_data[`CVT_WORD_BITS-1 -: HALF]);
				cfg.ch_step <= din_data[HALF-1:0];
			end else begin
				cfg.chpart_step <= din_data[`CVT_WORD_BITS-1 -: HALF];
				cfg.ch_part_num <= din_data[HALF-1:0];
			end
		end
	end

	// =========================================================================
	// bank memories
	// =========================================================================
	always_ff @(posedge clk) begin
		if (take & in_store) begin
			bank_mem[st_cnt[ST_W-1]][st_cnt[BANK_AW-1:0]] <= din_data;   // beats 0-15, 16-31
		end
		if (sort.step) begin
			bank_data <= bank_mem[sort.bank_sel][sort.bank_addr];
		end
	end

endmodule

// File: hw/cvt_sort_counter.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

module cvt_sort_counter (
	input  logic                  clk,
	input  logic                  reset,
	input  cvt_cfg_pkg::cvt_cfg_t cfg,
	cvt_ctrl_if.unit              ctrl,
	cvt_sort_if.source            sort
);
	localparam int LANE_W  = $clog2(`CVT_LANES);
	localparam int BANK_AW = $clog2(`CVT_BANK_DEPTH);
	localparam int SORT_AW = $clog2(`CVT_SORT_DEPTH);

	logic is_cm;       // channel-major transpose
	logic step;
	logic done;
	logic sort_fin;    // all addresses issued, wait for clear
	logic lane_wrap;
	logic part_wrap;
	logic bank_wrap;
	logic byte_wrap;
	logic [LANE_W-1:0]  lane_cnt;    // fastest
	logic               part_cnt;    // channel part, at most 2
	logic               bank_cnt;
	logic [LANE_W-1:0]  byte_cnt;
	logic [BANK_AW-1:0] col_part;    // slowest
	logic [SORT_AW-1:0] sort_addr;   // flat index in row-major mode
	cvt_cfg_pkg::cfg_field_t addr_sum;

	assign is_cm = (cfg.mode == cvt_types_pkg::MODE_CHANNEL_MAJOR);
	assign step  = (ctrl.state == cvt_types_pkg::SORT) & ~sort_fin;

	// carry chain of the nested counters
	assign lane_wrap = (lane_cnt == '1);
	assign part_wrap = (cvt_cfg_pkg::cfg_field_t'(part_cnt) == cfg.ch_part_num - 1);
	assign bank_wrap = bank_cnt;
	assign byte_wrap = (byte_cnt == '1);

	// last address of the frame
	assign done = step & (sort_addr == '1) & (~is_cm | lane_wrap);

	// =========================================================================
	// nested counters
	// =========================================================================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lane_cnt  <= '0;
			part_cnt  <= 1'b0;
			bank_cnt  <= 1'b0;
			byte_cnt  <= '0;
			col_part  <= '0;
			sort_addr <= '0;
			sort_fin  <= 1'b0;
		end else if (ctrl.clear) begin
			lane_cnt  <= '0;
			part_cnt  <= 1'b0;
			bank_cnt  <= 1'b0;
			byte_cnt  <= '0;
			col_part  <= '0;
			sort_addr <= '0;
			sort_fin  <= 1'b0;
		end else if (step) begin
			if (is_cm) begin
				lane_cnt <= lane_cnt + 1'b1;
				if (lane_wrap) begin
					part_cnt <= part_wrap ? 1'b0 : ~part_cnt;
				end
				if (lane_wrap & part_wrap) begin
					bank_cnt <= ~bank_cnt;
				end
				if (lane_wrap & part_wrap & bank_wrap) begin
					byte_cnt <= byte_cnt + 1'b1;
				end
				if (lane_wrap & part_wrap & bank_wrap & byte_wrap) begin
					col_part <= col_part + 1'b1;
				end
			end
			if (~is_cm | lane_wrap) begin
				sort_addr <= sort_addr + 1'b1;   // one entry per 8 lanes in transpose
			end
			sort_fin <= done;
		end
	end

	// bank word = lane*ch_step + ch_part*chpart_step + col_part
	assign addr_sum = cvt_cfg_pkg::cfg_field_t'(lane_cnt) * cfg.ch_step
		+ cvt_cfg_pkg::cfg_field_t'(part_cnt) * cfg.chpart_step
		+ cvt_cfg_pkg::cfg_field_t'(col_part);

	// row-major just splits the flat index
	assign sort.bank_sel  = is_cm ? bank_cnt : sort_addr[SORT_AW-1];
	assign sort.bank_addr = is_cm ? addr_sum[BANK_AW-1:0] : sort_addr[BANK_AW-1:0];
	assign sort.byte_sel  = byte_cnt;
	assign sort.lane      = is_cm ? {1'b0, lane_cnt} : (LANE_W+1)'(`CVT_LANES);  // full word
	assign sort.sort_addr = sort_addr;
	assign sort.step      = step;

	assign ctrl.sort_done = done;

endmodule

// File: hw/cvt_fsm.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

module cvt_fsm (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      din_empty_n,   // frame start
	cvt_ctrl_if.fsm                   ctrl,
	output cvt_types_pkg::cvt_state_e state
);
	localparam int CLR_N = `CVT_CLEAR_CYCLES;

	cvt_types_pkg::cvt_state_e state_q;
	cvt_types_pkg::cvt_state_e state_d;
	logic [1:0]       sort_dly;   // sort_done aged by two cycles
	logic [CLR_N-2:0] clr_sh;     // fills with ones during CLEAR_CNT

	// =========================================================================
	// state register
	// =========================================================================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q  <= cvt_types_pkg::IDLE;
			sort_dly <= '0;
			clr_sh   <= '0;
		end else begin
			state_q  <= state_d;
			sort_dly <= {sort_dly[0], ctrl.sort_done};   // in-flight sort writes drain
			if (state_q == cvt_types_pkg::CLEAR_CNT) begin
				clr_sh <= {clr_sh[CLR_N-3:0], 1'b1};
			end else begin
				clr_sh <= '0;
			end
		end
	end

	// next state on each phase's done pulse
	always_comb begin
		state_d = state_q;
		case (state_q)
			cvt_types_pkg::IDLE:
				state_d = din_empty_n ? cvt_types_pkg::CFG_READ : state_q;
			cvt_types_pkg::CFG_READ:
				state_d = ctrl.cfg_done ? cvt_types_pkg::STORE : state_q;
			cvt_types_pkg::STORE:
				state_d = ctrl.store_done ? cvt_types_pkg::SORT : state_q;
			cvt_types_pkg::SORT:
				state_d = sort_dly[1] ? cvt_types_pkg::OUTPUT : state_q;   // last write landed
			cvt_types_pkg::OUTPUT:
				state_d = ctrl.out_done ? cvt_types_pkg::CLEAR_CNT : state_q;
			cvt_types_pkg::CLEAR_CNT:
				state_d = clr_sh[CLR_N-2] ? cvt_types_pkg::IDLE : state_q;  // CLR_N cycles
			default:
				state_d = cvt_types_pkg::IDLE;
		endcase
	end

	assign ctrl.state = state_q;
	assign ctrl.clear = (state_q == cvt_types_pkg::CLEAR_CNT);
	assign state      = state_q;   // observation copy

endmodule

// File: hw/cvt_sort_if.sv
`timescale 1ns/1ps
`include "cvt_consts.svh"

// sort addressing, from the sort counter to the banks and the sort memory
interface cvt_sort_if;

	logic [$clog2(`CVT_BANK_DEPTH)-1:0] bank_addr;   // word inside the bank
	logic                               bank_sel;    // 0 = first half of payload
	logic [$clog2(`CVT_LANES)-1:0]      byte_sel;    // byte taken from the bank word
	logic [$clog2(`CVT_LANES):0]        lane;        // target byte lane, LANES = whole word
	logic [$clog2(`CVT_SORT_DEPTH)-1:0] sort_addr;   // sort memory entry
	logic                               step;        // high on each sort cycle

	modport source (
		output bank_addr,
		output bank_sel,
		output byte_sel,
		output lane,
		output sort_addr,
		output step
	);

	modport sink (
		input  bank_addr,
		input  bank_sel,
		input  byte_sel,
		input  lane,
		input  sort_addr,
		input  step
	);

endinterface

// File: hw/cvt_ctrl_if.sv
`timescale 1ns/1ps

// phase control between the FSM and the data units
interface cvt_ctrl_if;

	cvt_types_pkg::cvt_state_e state;   // current phase
	logic clear;                        // counter clear, high during CLEAR_CNT

	// one-cycle pulses in the last cycle of each phase
	logic cfg_done;      // store unit
	logic store_done;    // store unit
	logic sort_done;     // sort counter, last address issued
	logic out_done;      // sort memory, last beat accepted

	modport fsm (
		output state,
		output clear,
		input  cfg_done,
		input  store_done,
		input  sort_done,
		input  out_done
	);

	modport unit (
		input  state,
		input  clear,
		output cfg_done,
		output store_done,
		output sort_done,
		output out_done
	);

endinterface

// File: hw/cvt_cfg_pkg.sv
package cvt_cfg_pkg;

	// one half of a config beat
	typedef logic [31:0] cfg_field_t;

	// assembled frame configuration
	// beat 0 = {mode, ch_step}
	// beat 1 = {chpart_step, ch_part_num}
	typedef struct packed {
		cvt_types_pkg::cvt_mode_e mode;
		cfg_field_t ch_step;        // bank address step between channels
		cfg_field_t chpart_step;    // bank address step between channel parts
		cfg_field_t ch_part_num;    // 1 or 2 channel parts
	} cvt_cfg_t;

endpackage

// File: hw/cvt_types_pkg.sv
package cvt_types_pkg;

	// converter phase, one frame walks through all of them in order
	typedef enum logic [2:0] {
		IDLE,
		CFG_READ,     // two config beats
		STORE,        // payload into the banks
		SORT,         // banks -> sort memory
		OUTPUT,       // sort memory -> output stream
		CLEAR_CNT     // counters back to zero
	} cvt_state_e;

	// upper half of config beat 0
	typedef enum logic [31:0] {
		MODE_CHANNEL_MAJOR = 32'd1,   // byte transpose for 1x1 conv
		MODE_ROW_MAJOR     = 32'd2    // straight copy, unknown codes land here too
	} cvt_mode_e;

endpackage

// File: hw/cvt_consts.svh
`ifndef CVT_CONSTS_SVH
`define CVT_CONSTS_SVH

// =========================================================================
// stream geometry
// =========================================================================
`define CVT_WORD_BITS    64    // one stream beat
`define CVT_LANES        8     // bytes per beat

// memory sizing, scaled down so a frame simulates quickly
`define CVT_BANK_DEPTH   16    // words per store bank
`define CVT_SORT_DEPTH   32    // sort entries, also output beats per frame

// frame sequencing
`define CVT_CFG_WORDS    2     // mode/ch_step beat, then chpart_step/ch_part_num beat
`define CVT_CLEAR_CYCLES 3     // length of the counter clear phase

`endif
